//--- hdl/cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

//////////////////////////////
// image and filter geometry
//////////////////////////////
`define CNN_IMG_SIDE 8          // input image is square
`define CNN_KERNEL 3            // filter side
`define CNN_CONV_SIDE 6         // valid convolution output side
`define CNN_FEAT_SIDE 3         // side after 2x2 pooling

//////////////////////////////
// dense layer
//////////////////////////////
`define CNN_FEATURES 9          // pooled features into the dense layer
`define CNN_CLASSES 4
`define CNN_WEIGHTS 36          // classes times features, class-major

`define CNN_PIXEL_MAX 255       // rectifier saturation level

`endif

//--- hdl/cnn_pkg.sv
`include "cnn_consts.svh"

package cnn_pkg;

    typedef logic [7:0] pixel_t;                // unsigned pixel or feature
    typedef logic signed [7:0] coef_t;          // filter tap or dense weight

    // one load byte, pixel for the image, coefficient for everything else
    typedef union packed
    {
        pixel_t pixel;
        coef_t  coef;
    } load_word_u;

    typedef enum logic [1:0]
    {
        TGT_IMAGE  = 2'd0,
        TGT_FILTER = 2'd1,
        TGT_WEIGHT = 2'd2
    } load_target_e;

    typedef struct packed
    {
        load_target_e target;
        logic [5:0]   addr;                     // row-major index
        load_word_u   word;
    } load_cmd_t;

    typedef pixel_t [`CNN_KERNEL*`CNN_KERNEL-1:0] window_t;     // index 0 is top-left
    typedef coef_t [`CNN_KERNEL*`CNN_KERNEL-1:0] kernel_t;
    typedef pixel_t [`CNN_FEATURES-1:0] feature_map_t;

    typedef logic signed [19:0] score_t;
    typedef logic [1:0] class_t;

    typedef struct packed
    {
        class_t                    win_class;
        score_t [`CNN_CLASSES-1:0] scores;
    } result_t;

endpackage

//--- hdl/load_port.sv
`timescale 1ns/1ns

module load_port
    import cnn_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_req,
    input  load_cmd_t load_cmd,
    input  logic      busy,
    output logic      load_ack,
    output logic      wr_en,
    output load_cmd_t wr_cmd
);

    logic take;

    // load_ack is the whole FSM state, low means waiting for a request
    assign take = load_req && !load_ack && !busy;   // held off while a run is active

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            load_ack <= 1'b0;
            wr_en    <= 1'b0;
        end
        else
        begin
            wr_en <= take;                          // single strobe per command
            if (take)
            begin
                load_ack <= 1'b1;
            end
            else if (!load_req)
            begin
                load_ack <= 1'b0;                   // return to zero
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            wr_cmd <= load_cmd;
        end
    end

    // host keeps req up until it has seen the ack
    a_req_held: assert property (@(posedge clk) disable iff (!reset)
        $fell(load_req) |-> load_ack);

endmodule

//--- hdl/run_control.sv
`timescale 1ns/1ns

module run_control
    import cnn_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic run_req,
    input  logic conv_done,
    input  logic dense_done,
    output logic conv_go,
    output logic dense_go,
    output logic busy,
    output logic run_ack
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_CONV  = 2'd1;
    localparam logic [1:0] S_DENSE = 2'd2;
    localparam logic [1:0] S_ACK   = 2'd3;

    logic [1:0] state;

    // covers the cycle the request is first seen, and the ack phase
    assign busy = run_req || (state != S_IDLE);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state    <= S_IDLE;
            conv_go  <= 1'b0;
            dense_go <= 1'b0;
            run_ack  <= 1'b0;
        end
        else
        begin
            conv_go  <= 1'b0;
            dense_go <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (run_req)
                    begin
                        state   <= S_CONV;
                        conv_go <= 1'b1;
                    end
                end
                S_CONV:
                begin
                    if (conv_done)
                    begin
                        state    <= S_DENSE;
                        dense_go <= 1'b1;     // feature map is now held
                    end
                end
                S_DENSE:
                begin
                    if (dense_done)
                    begin
                        state   <= S_ACK;
                        run_ack <= 1'b1;
                    end
                end
                default:
                begin
                    if (!run_req)
                    begin
                        state   <= S_IDLE;
                        run_ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    // the dense layer only reports done to close a dense phase started here
    a_done_in_dense: assert property (@(posedge clk) disable iff (!reset)
        dense_done |-> state == S_DENSE);

endmodule

//--- hdl/image_memory.sv
`timescale 1ns/1ns
`include "cnn_consts.svh"

module image_memory
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  load_cmd_t  wr_cmd,
    input  logic [2:0] win_row,
    input  logic [2:0] win_col,
    output window_t    window
);

    pixel_t  mem [0:`CNN_IMG_SIDE*`CNN_IMG_SIDE-1];
    window_t win_next;

    always_ff @(posedge clk)
    begin
        if (wr_en && wr_cmd.target == TGT_IMAGE)
        begin
            mem[wr_cmd.addr] <= wr_cmd.word.pixel;     // all 64 addresses valid
        end
    end

    //////////////////////////////
    // 3x3 window gather
    //////////////////////////////
    always_comb
    begin
        for (int r = 0; r < `CNN_KERNEL; r++)
        begin
            for (int c = 0; c < `CNN_KERNEL; c++)
            begin
                win_next[r*`CNN_KERNEL+c] = mem[{win_row + 3'(r), win_col + 3'(c)}];
            end
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            window <= '0;
        end
        else
        begin
            window <= win_next;                        // one cycle after the address
        end
    end

endmodule

//--- hdl/coef_store.sv
`timescale 1ns/1ns
`include "cnn_consts.svh"

module coef_store
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  load_cmd_t  wr_cmd,
    output kernel_t    kernel,
    input  logic [5:0] w_addr,
    output coef_t      weight
);

    coef_t wmem [0:`CNN_WEIGHTS-1];                   // class-major
    logic  wr_filter;
    logic  wr_weight;

    // out-of-range addresses fall through silently
    assign wr_filter = wr_en && wr_cmd.target == TGT_FILTER
                       && wr_cmd.addr < `CNN_KERNEL*`CNN_KERNEL;
    assign wr_weight = wr_en && wr_cmd.target == TGT_WEIGHT
                       && wr_cmd.addr < `CNN_WEIGHTS;

    //////////////////////////////
    // filter register bank
    //////////////////////////////
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            kernel <= '0;
        end
        else if (wr_filter)
        begin
            kernel[wr_cmd.addr] <= wr_cmd.word.coef;  // coefficient view
        end
    end

    //////////////////////////////
    // dense weights
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (wr_weight)
        begin
            wmem[wr_cmd.addr] <= wr_cmd.word.coef;
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            weight <= '0;
        end
        else
        begin
            weight <= wmem[w_addr];                   // registered read
        end
    end

endmodule

//--- hdl/conv_pool_engine.sv
`timescale 1ns/1ns
`include "cnn_consts.svh"

module conv_pool_engine
    import cnn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         conv_go,
    input  window_t      window,
    input  kernel_t      kernel,
    output logic [2:0]   win_row,
    output logic [2:0]   win_col,
    output feature_map_t features,
    output logic         conv_done
);

    logic        scanning;
    logic [1:0]  grp_row;                       // pool group
    logic [1:0]  grp_col;
    logic [1:0]  sub;                           // window inside the group
    logic [3:0]  feat_idx;

    // stage 1 has the window from memory, stage 2 the registered sum
    logic        v1;
    logic        v2;
    logic        first1;
    logic        first2;
    logic        last1;
    logic        last2;
    logic [3:0]  idx1;
    logic [3:0]  idx2;

    logic signed [19:0] conv_sum;               // room for 9 full-scale products
    logic signed [19:0] sum_q;
    pixel_t      relu;
    pixel_t      pool_max;
    pixel_t      pool_next;

    // group index gives the upper address bits, sub picks the 2x2 offset
    assign win_row  = {grp_row, sub[1]};
    assign win_col  = {grp_col, sub[0]};
    assign feat_idx = grp_row * 4'(`CNN_FEAT_SIDE) + 4'(grp_col);

    //////////////////////////////
    // window address scan
    //////////////////////////////
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            scanning <= 1'b0;
            grp_row  <= '0;
            grp_col  <= '0;
            sub      <= '0;
        end
        else if (conv_go)
        begin
            scanning <= 1'b1;
            grp_row  <= '0;
            grp_col  <= '0;
            sub      <= '0;
        end
        else if (scanning)
        begin
            sub <= sub + 2'd1;
            if (sub == 2'd3)
            begin
                if (grp_col == `CNN_CONV_SIDE/2-1)
                begin
                    grp_col <= '0;
                    if (grp_row == `CNN_CONV_SIDE/2-1)
                    begin
                        scanning <= 1'b0;       // 36th window issued
                    end
                    else
                    begin
                        grp_row <= grp_row + 2'd1;
                    end
                end
                else
                begin
                    grp_col <= grp_col + 2'd1;
                end
            end
        end
    end

    //////////////////////////////
    // convolution, rectify, pool
    //////////////////////////////
    always_comb
    begin
        conv_sum = '0;
        for (int i = 0; i < `CNN_KERNEL*`CNN_KERNEL; i++)
        begin
            conv_sum = conv_sum + $signed({1'b0, window[i]}) * $signed(kernel[i]);
        end
    end

    always_comb
    begin
        if (sum_q < 0)
        begin
            relu = '0;
        end
        else if (sum_q > `CNN_PIXEL_MAX)
        begin
            relu = pixel_t'(`CNN_PIXEL_MAX);
        end
        else
        begin
            relu = sum_q[7:0];
        end
        pool_next = (first2 || relu > pool_max) ? relu : pool_max;
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            conv_done <= 1'b0;
        end
        else
        begin
            v1        <= scanning;
            v2        <= v1;
            conv_done <= v2 && last2 && idx2 == `CNN_FEATURES-1;
        end
    end

    always_ff @(posedge clk)
    begin
        first1 <= (sub == 2'd0);
        last1  <= (sub == 2'd3);
        idx1   <= feat_idx;
        first2 <= first1;
        last2  <= last1;
        idx2   <= idx1;
        sum_q  <= conv_sum;
        if (v2)
        begin
            pool_max <= pool_next;
        end
        if (v2 && last2)
        begin
            features[idx2] <= pool_next;        // group finished
        end
    end

    // a run may only start once the previous scan has drained
    a_go_idle: assert property (@(posedge clk) disable iff (!reset)
        conv_go |-> !(scanning || v1 || v2));

endmodule

//--- hdl/dense_layer.sv
`timescale 1ns/1ns
`include "cnn_consts.svh"

module dense_layer
    import cnn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         dense_go,
    input  feature_map_t features,
    output logic [5:0]   w_addr,
    input  coef_t        weight,
    output result_t      result,
    output logic         dense_done
);

    logic       active;
    logic [3:0] k0;                             // feature for the issued address
    class_t     cls0;
    logic       v1;                             // weight arrives this cycle
    logic [3:0] k1;
    class_t     cls1;
    logic       last1;
    score_t     acc;
    score_t     acc_base;
    score_t     mac_sum;

    assign last1 = v1 && k1 == `CNN_FEATURES-1;

    always_comb
    begin
        if (k1 == 4'd0)
        begin
            acc_base = '0;                      // new class
        end
        else
        begin
            acc_base = acc;
        end
        mac_sum = acc_base + $signed({1'b0, features[k1]}) * $signed(weight);
    end

    //////////////////////////////
    // weight address walk
    //////////////////////////////
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            active     <= 1'b0;
            w_addr     <= '0;
            k0         <= '0;
            cls0       <= '0;
            v1         <= 1'b0;
            k1         <= '0;
            cls1       <= '0;
            dense_done <= 1'b0;
        end
        else
        begin
            v1         <= active;
            k1         <= k0;
            cls1       <= cls0;
            dense_done <= last1 && cls1 == `CNN_CLASSES-1;
            if (dense_go)
            begin
                active <= 1'b1;
                w_addr <= '0;
                k0     <= '0;
                cls0   <= '0;
            end
            else if (active)
            begin
                w_addr <= w_addr + 6'd1;
                if (k0 == `CNN_FEATURES-1)
                begin
                    k0   <= '0;
                    cls0 <= cls0 + 2'd1;
                end
                else
                begin
                    k0 <= k0 + 4'd1;
                end
                if (w_addr == `CNN_WEIGHTS-1)
                begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (v1)
        begin
            acc <= mac_sum;
        end
    end

    //////////////////////////////
    // scores and running argmax
    //////////////////////////////
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            result <= '0;
        end
        else if (last1)
        begin
            result.scores[cls1] <= mac_sum;
            // strictly greater, so ties keep the lower class
            if (cls1 == 2'd0 || mac_sum > $signed(result.scores[result.win_class]))
            begin
                result.win_class <= cls1;
            end
        end
    end

endmodule

//--- hdl/cnn_top.sv
`timescale 1ns/1ns

module cnn_top
    import cnn_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_req,
    input  load_cmd_t load_cmd,
    output logic      load_ack,
    input  logic      run_req,
    output logic      run_ack,
    output result_t   result
);

    logic         busy;
    logic         wr_en;
    load_cmd_t    wr_cmd;
    logic         conv_go;
    logic         conv_done;
    logic         dense_go;
    logic         dense_done;
    logic [2:0]   win_row;
    logic [2:0]   win_col;
    window_t      window;
    kernel_t      kernel;
    feature_map_t features;
    logic [5:0]   w_addr;
    coef_t        weight;

    load_port u_load_port (.clk(clk), .reset(reset), .load_req(load_req), .load_cmd(load_cmd),
        .busy(busy), .load_ack(load_ack), .wr_en(wr_en), .wr_cmd(wr_cmd));

    run_control u_run_control (.clk(clk), .reset(reset), .run_req(run_req),
        .conv_done(conv_done), .dense_done(dense_done), .conv_go(conv_go),
        .dense_go(dense_go), .busy(busy), .run_ack(run_ack));

    image_memory u_image_memory (.clk(clk), .reset(reset), .wr_en(wr_en), .wr_cmd(wr_cmd),
        .win_row(win_row), .win_col(win_col), .window(window));

    coef_store u_coef_store (.clk(clk), .reset(reset), .wr_en(wr_en), .wr_cmd(wr_cmd),
        .kernel(kernel), .w_addr(w_addr), .weight(weight));

    // convolution and pooling into the held feature map
    conv_pool_engine u_conv_pool_engine (.clk(clk), .reset(reset), .conv_go(conv_go),
        .window(window), .kernel(kernel), .win_row(win_row), .win_col(win_col),
        .features(features), .conv_done(conv_done));

    dense_layer u_dense_layer (.clk(clk), .reset(reset), .dense_go(dense_go),
        .features(features), .w_addr(w_addr), .weight(weight), .result(result),
        .dense_done(dense_done));

endmodule

//--- verification/tb_cnn.sv
`timescale 1ns/1ns
`include "cnn_consts.svh"

module tb_cnn
    import cnn_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int N_CASES         = 5;
    localparam int N_PIXELS        = `CNN_IMG_SIDE*`CNN_IMG_SIDE;
    localparam int N_TAPS          = `CNN_KERNEL*`CNN_KERNEL;
    localparam int OFS_PIX         = 1;                        // word 0 is the mode flag
    localparam int OFS_COEF        = OFS_PIX + N_PIXELS;
    localparam int OFS_WGT         = OFS_COEF + N_TAPS;
    localparam int OFS_SCORE       = OFS_WGT + `CNN_WEIGHTS;
    localparam int OFS_CLASS       = OFS_SCORE + `CNN_CLASSES;
    localparam int CASE_WORDS      = OFS_CLASS + 1;
    localparam int LOAD_CYCLES     = 12;
    localparam int RUN_CYCLES      = 200;
    localparam int HANDSHAKE_LIMIT = 20;
    localparam int LOADS_PER_CASE  = N_PIXELS + N_TAPS + `CNN_WEIGHTS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES
                                     + N_CASES*(LOADS_PER_CASE*LOAD_CYCLES + RUN_CYCLES);

    logic        clk;
    logic        reset;
    logic        load_req;
    load_cmd_t   load_cmd;
    logic        load_ack;
    logic        run_req;
    logic        run_ack;
    result_t     result;
    logic [19:0] case_mem [0:N_CASES*CASE_WORDS-1];
    int unsigned seed_val;

    cnn_top dut0 (.clk(clk), .reset(reset), .load_req(load_req), .load_cmd(load_cmd),
        .load_ack(load_ack), .run_req(run_req), .run_ack(run_ack), .result(result));

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    task automatic end_with_failure();
        $display("sim failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_class(input string name, input class_t exp, input class_t act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    //////////////////////////////
    // handshake drivers
    //////////////////////////////
    task automatic idle_gap();
        int n;
        n = $urandom % 4;                                      // 0 to 3 idle cycles
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_load_ack(input logic level);
        int n;
        n = 0;
        while (load_ack !== level)
        begin
            if (n == HANDSHAKE_LIMIT)
            begin
                $display("load handshake stuck: load_ack never went to %0b (time %0t ns)",
                         level, $time);
                end_with_failure();
            end
            else
            begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic finish_load();
        wait_load_ack(1'b1);
        idle_gap();
        check_bit("load_ack", 1'b1, load_ack);                 // held while req is high
        load_req = 1'b0;
        @(negedge clk);
        wait_load_ack(1'b0);                                   // return to zero
        idle_gap();
    endtask

    task automatic send_load(input load_target_e tgt, input logic [5:0] addr,
                             input logic [7:0] data);
        check_bit("load_ack", 1'b0, load_ack);
        load_cmd.target     = tgt;
        load_cmd.addr       = addr;
        load_cmd.word.pixel = data;                            // raw byte
        load_req            = 1'b1;
        @(negedge clk);
        finish_load();
    endtask

    task automatic load_case(input int base);
        if (case_mem[base] != 20'd0)
        begin
            for (int i = 0; i < N_PIXELS; i++)
            begin
                send_load(TGT_IMAGE, 6'(i), case_mem[base+OFS_PIX+i][7:0]);
            end
            for (int i = 0; i < N_TAPS; i++)
            begin
                send_load(TGT_FILTER, 6'(i), case_mem[base+OFS_COEF+i][7:0]);
            end
        end
        for (int i = 0; i < `CNN_WEIGHTS; i++)
        begin
            send_load(TGT_WEIGHT, 6'(i), case_mem[base+OFS_WGT+i][7:0]);
        end
    endtask

    // run with a load raised in the middle, which must stay unanswered until run_ack falls
    task automatic run_case(input int base);
        int n;
        check_bit("run_ack", 1'b0, run_ack);
        run_req = 1'b1;
        @(negedge clk);
        load_cmd.target     = TGT_WEIGHT;
        load_cmd.addr       = 6'd63;                           // out of range so never written
        load_cmd.word.pixel = 8'h55;
        load_req            = 1'b1;
        n = 0;
        while (run_ack !== 1'b1)
        begin
            if (n == RUN_CYCLES)
            begin
                $display("run handshake stuck: run_ack did not rise within %0d cycles",
                         RUN_CYCLES);
                end_with_failure();
            end
            else
            begin
                @(negedge clk);
                check_bit("load_ack", 1'b0, load_ack);
                n++;
            end
        end
        for (int q = 0; q < `CNN_CLASSES; q++)
        begin
            check_score($sformatf("result.scores[%0d]", q),
                        score_t'(case_mem[base+OFS_SCORE+q]), result.scores[q]);
        end
        check_class("result.win_class", class_t'(case_mem[base+OFS_CLASS]), result.win_class);
        idle_gap();
        run_req = 1'b0;
        n = 0;
        while (run_ack !== 1'b0)
        begin
            if (n == HANDSHAKE_LIMIT)
            begin
                $display("run handshake stuck: run_ack stayed high after run_req fell");
                end_with_failure();
            end
            else
            begin
                @(negedge clk);
                check_bit("load_ack", 1'b0, load_ack);         // still held off
                n++;
            end
        end
        finish_load();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial
    begin
        seed_val = $urandom(32'h13c2);
        reset    = 1'b0;
        load_req = 1'b0;
        load_cmd = '0;
        run_req  = 1'b0;
        $readmemh("verification/cnn_cases.txt", case_mem);
        if ($isunknown(case_mem[N_CASES*CASE_WORDS-1]))
        begin
            $display("the case file verification/cnn_cases.txt is missing or too short");
            end_with_failure();
        end
        else
        begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            reset = 1'b1;
            @(negedge clk);
            check_bit("load_ack", 1'b0, load_ack);
            check_bit("run_ack", 1'b0, run_ack);
            for (int q = 0; q < `CNN_CLASSES; q++)
            begin
                check_score($sformatf("result.scores[%0d]", q), '0, result.scores[q]);
            end
            check_class("result.win_class", '0, result.win_class);
            for (int c = 0; c < N_CASES; c++)
            begin
                load_case(c*CASE_WORDS);
                run_case(c*CASE_WORDS);
            end
            $display("sim passed");
            $finish;
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES*CLK_PERIOD);
        $display("watchdog expired: the test did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        end_with_failure();
    end

endmodule

//--- files.f
+incdir+hdl
hdl/cnn_pkg.sv
hdl/load_port.sv
hdl/run_control.sv
hdl/image_memory.sv
hdl/coef_store.sv
hdl/conv_pool_engine.sv
hdl/dense_layer.sv
hdl/cnn_top.sv
verification/tb_cnn.sv

//--- verification/cnn_cases.txt
// mode (1 full load, 0 weights only), pixels[64] row-major, filter[9], weights[36] class-major,
// expected scores[4] as 20-bit two's complement, expected class
// general case, pixel = address, filter -1 top-left and 2 centre
1  00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f  ff 00 00 00 02 00 00 00 00  01 01 01 01 01 01 01 01 01 ff ff ff ff ff ff ff ff ff 02 02 02 02 02 02 02 02 02 ff 00 00 00 00 00 00 00 03  00195 ffe6b 0032a 000a2  2
// strongly positive filter, every feature saturates at 255
1  00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f  7f 7f 7f 7f 7f 7f 7f 7f 7f  01 01 01 01 01 01 01 01 01 00 00 00 00 00 00 00 00 00 ff 00 00 00 00 00 00 00 00 01 01 01 01 00 00 00 00 00  008f7 00000 fff01 003fc  0
// all-negative filter, features rectified to zero
1  00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f  ff ff ff ff ff ff ff ff ff  01 01 01 01 01 01 01 01 01 ff ff ff ff ff ff ff ff ff 02 02 02 02 02 02 02 02 02 ff 00 00 00 00 00 00 00 03  00000 00000 00000 00000  0
// classes 1 and 2 tie on the top score
1  00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f  ff 00 00 00 02 00 00 00 00  00 00 00 00 00 00 00 00 00 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 ff ff ff ff ff ff ff ff ff  00000 00195 00195 ffe6b  1
// weights only, image and filter kept from the case above
0  00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00  00 00 00 00 05 00 00 00 00 00 00 00 00 00 00 00 00 fe 00 00 00 00 00 00 00 00 00 01 00 00 00 00 00 00 00 04  000e1 fff82 00000 00117  3
